// File: logic/eth_stats_params.svh
// --------------------------------------------------
// Record size, record header constants and default
// log beat width, shared by the packer and the top.
// --------------------------------------------------
`ifndef ETH_STATS_PARAMS_SVH
`define ETH_STATS_PARAMS_SVH

// size of one log record in bits.
`define ETH_LOG_RECORD_BITS 512

// default beat width of the log stream.
`define ETH_LOG_WIDTH_DEFAULT 64

// tag in the lowest 32 bits of each record.
`define ETH_LOG_MAGIC 32'h02425AFF

// payload bytes that follow the 8-byte record header.
`define ETH_LOG_LENGTH 16'd56

`endif

// File: logic/eth_frame_pkg.sv
// --------------------------------------------------
// Frame-side types, shared by the frame counters, the
// log packer and the top level.
// --------------------------------------------------
`default_nettype none

package eth_frame_pkg;

	// status reported with each frame completion strobe.
	typedef enum logic {
		FRAME_BAD  = 1'b0,
		FRAME_GOOD = 1'b1
	} frame_status_t;

	// --------------------------------------------------
	// Totals of one direction
	// --------------------------------------------------

	// all three fields are free-running 64-bit totals from reset.
	typedef struct packed {
		logic [63:0] bytes;
		logic [63:0] good;
		logic [63:0] bad;
	} stats_counts_t;

endpackage

`default_nettype wire

// File: logic/eth_log_pkg.sv
// --------------------------------------------------
// Log-side types for the record packer.
// --------------------------------------------------
`default_nettype none

package eth_log_pkg;

	// --------------------------------------------------
	// Packer state
	// --------------------------------------------------

	// LOG_IDLE waits for a trigger.
	// LOG_SEND streams the captured record one beat at a time
	// and goes back to idle after the tlast transfer.
	typedef enum logic {
		LOG_IDLE = 1'b0,
		LOG_SEND = 1'b1
	} log_state_t;

endpackage

`default_nettype wire

// File: logic/eth_frame_counter.sv
// --------------------------------------------------
// Byte, good-frame and bad-frame totals for one
// direction, fed by per-frame completion strobes.
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module eth_frame_counter (
	input  logic                          clk,
	input  logic                          rst_n,

	// one strobe per completed frame, length and status valid with it.
	input  logic                          frame_done,
	input  logic [15:0]                   frame_len,
	input  eth_frame_pkg::frame_status_t  frame_status,

	output eth_frame_pkg::stats_counts_t  counts
);
	import eth_frame_pkg::*;

	logic [63:0] len_ext;

	// the frame length widened to the size of the byte total.
	assign len_ext = {48'd0, frame_len};

	// --------------------------------------------------
	// Accumulators
	// --------------------------------------------------

	// a strobe at one edge is visible in the totals right after it.
	// the counter never stalls, so every strobe is taken.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			counts.bytes <= 64'd0;
			counts.good  <= 64'd0;
			counts.bad   <= 64'd0;
		end else if (frame_done) begin
			counts.bytes <= counts.bytes + len_ext;

			// exactly one of good and bad moves per frame.
			if (frame_status == FRAME_GOOD) begin
				counts.good <= counts.good + 64'd1;
			end else begin
				counts.bad <= counts.bad + 64'd1;
			end
		end
	end

	// the byte total counts bad frames as well.
	// a frame length of zero still counts as one frame.

endmodule

`default_nettype wire

// File: logic/eth_stats_log_packer.sv
// --------------------------------------------------
// Snapshots both directions' totals on a trigger and
// streams them as one 512-bit record in log_width beats.
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "eth_stats_params.svh"

module eth_stats_log_packer #(
	parameter int log_width = `ETH_LOG_WIDTH_DEFAULT
) (
	input  logic                          clk,
	input  logic                          rst_n,

	input  logic                          trigger,
	input  logic [15:0]                   log_id,
	input  eth_frame_pkg::stats_counts_t  tx_counts,
	input  eth_frame_pkg::stats_counts_t  rx_counts,
	output logic [63:0]                   overflow_count,

	// log stream master.
	output logic [log_width-1:0]          m_axis_log_tdata,
	output logic                          m_axis_log_tlast,
	output logic                          m_axis_log_tvalid,
	input  logic                          m_axis_log_tready
);
	import eth_log_pkg::*;

	// number of beats per record and the size of the beat counter.
	localparam int beat_count = `ETH_LOG_RECORD_BITS / log_width;
	localparam int cnt_width  = (beat_count > 1) ? $clog2(beat_count) : 1;
	localparam logic [cnt_width-1:0] last_beat = cnt_width'(beat_count - 1);

	log_state_t                       state;
	logic [cnt_width-1:0]             beat_cnt;
	logic [`ETH_LOG_RECORD_BITS-1:0]  shift_buf;
	logic [`ETH_LOG_RECORD_BITS-1:0]  record;
	logic [63:0]                      timestamp;
	logic                             beat_done;

	// --------------------------------------------------
	// Timestamp
	// --------------------------------------------------

	// free-running cycle count, zero while in reset.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			timestamp <= 64'd0;
		end else begin
			timestamp <= timestamp + 64'd1;
		end
	end

	// --------------------------------------------------
	// Record assembly
	// --------------------------------------------------

	// the header sits in the low 64 bits, so it leaves in the first beat.
	assign record = {
		rx_counts.bad, rx_counts.good, rx_counts.bytes,
		tx_counts.bad, tx_counts.good, tx_counts.bytes,
		timestamp,
		`ETH_LOG_LENGTH, log_id, `ETH_LOG_MAGIC
	};

	assign beat_done = m_axis_log_tvalid && m_axis_log_tready;

	// --------------------------------------------------
	// Sending FSM
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state          <= LOG_IDLE;
			beat_cnt       <= '0;
			overflow_count <= 64'd0;
		end else begin
			case (state)
				LOG_IDLE: begin
					if (trigger) begin
						state    <= LOG_SEND;
						beat_cnt <= '0;
					end
				end
				LOG_SEND: begin
					// a trigger while busy is only counted.
					if (trigger) begin
						overflow_count <= overflow_count + 64'd1;
					end
					if (beat_done) begin
						if (m_axis_log_tlast) begin
							state <= LOG_IDLE;
						end else begin
							beat_cnt <= beat_cnt + cnt_width'(1);
						end
					end
				end
				default: state <= LOG_IDLE;
			endcase
		end
	end

	// the buffer is loaded at the trigger and shifted down one beat
	// per transfer, so the current beat is always in the low bits.
	always_ff @(posedge clk) begin
		if (state == LOG_IDLE && trigger) begin
			shift_buf <= record;
		end else if (beat_done) begin
			shift_buf <= shift_buf >> log_width;
		end
	end

	assign m_axis_log_tdata  = shift_buf[log_width-1:0];
	assign m_axis_log_tvalid = (state == LOG_SEND);
	assign m_axis_log_tlast  = (state == LOG_SEND) && (beat_cnt == last_beat);

endmodule

`default_nettype wire

// File: logic/eth_stats_collector.sv
// --------------------------------------------------
// Statistics top level with a transmit counter, a receive
// counter and the log packer behind plain ports.
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "eth_stats_params.svh"

module eth_stats_collector (
	input  logic                               clk,
	input  logic                               rst_n,

	// transmit frame completions.
	input  logic                               tx_frame_done,
	input  logic [15:0]                        tx_frame_len,
	input  logic                               tx_frame_ok,

	// receive frame completions.
	input  logic                               rx_frame_done,
	input  logic [15:0]                        rx_frame_len,
	input  logic                               rx_frame_ok,

	input  logic                               log_trigger,
	input  logic [15:0]                        log_id,
	output logic [63:0]                        overflow_count,

	// log stream master.
	output logic [`ETH_LOG_WIDTH_DEFAULT-1:0]  m_axis_log_tdata,
	output logic                               m_axis_log_tlast,
	output logic                               m_axis_log_tvalid,
	input  logic                               m_axis_log_tready
);
	import eth_frame_pkg::*;

	frame_status_t tx_status;
	frame_status_t rx_status;
	stats_counts_t tx_counts;
	stats_counts_t rx_counts;

	// a high ok bit means a good frame.
	assign tx_status = frame_status_t'(tx_frame_ok);
	assign rx_status = frame_status_t'(rx_frame_ok);

	// --------------------------------------------------
	// Per-direction counters
	// --------------------------------------------------

	eth_frame_counter tx_counter (
		.clk          (clk),
		.rst_n        (rst_n),
		.frame_done   (tx_frame_done),
		.frame_len    (tx_frame_len),
		.frame_status (tx_status),
		.counts       (tx_counts)
	);

	eth_frame_counter rx_counter (
		.clk          (clk),
		.rst_n        (rst_n),
		.frame_done   (rx_frame_done),
		.frame_len    (rx_frame_len),
		.frame_status (rx_status),
		.counts       (rx_counts)
	);

	// --------------------------------------------------
	// Record packer
	// --------------------------------------------------

	eth_stats_log_packer #(
		.log_width (`ETH_LOG_WIDTH_DEFAULT)
	) log_packer (
		.clk               (clk),
		.rst_n             (rst_n),
		.trigger           (log_trigger),
		.log_id            (log_id),
		.tx_counts         (tx_counts),
		.rx_counts         (rx_counts),
		.overflow_count    (overflow_count),
		.m_axis_log_tdata  (m_axis_log_tdata),
		.m_axis_log_tlast  (m_axis_log_tlast),
		.m_axis_log_tvalid (m_axis_log_tvalid),
		.m_axis_log_tready (m_axis_log_tready)
	);

endmodule

`default_nettype wire

// File: sim/eth_stats_checker.sv
// --------------------------------------------------
// Watches the log stream, rebuilds each record from its
// beats and compares it with the queued expected record.
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "eth_stats_params.svh"

module eth_stats_checker (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [`ETH_LOG_WIDTH_DEFAULT-1:0]  tdata,
	input  logic                               tlast,
	input  logic                               tvalid,
	input  logic                               tready,
	input  logic [63:0]                        overflow_count
);
	import eth_log_pkg::*;

	localparam int beat_width       = `ETH_LOG_WIDTH_DEFAULT;
	localparam int beats_per_record = `ETH_LOG_RECORD_BITS / beat_width;

	// expected records and their test names, oldest first.
	logic [`ETH_LOG_RECORD_BITS-1:0] expected_q[$];
	string                           name_q[$];

	int pass_count = 0;
	int fail_count = 0;

	// LOG_SEND while a record is only partly received.
	log_state_t                      rec_state = LOG_IDLE;
	int                              beat_idx  = 0;
	logic [`ETH_LOG_RECORD_BITS-1:0] assembled;
	logic                            held      = 1'b0;
	logic [beat_width-1:0]           held_data;

	task automatic push_expected(input logic [`ETH_LOG_RECORD_BITS-1:0] rec, input string name);
		expected_q.push_back(rec);
		name_q.push_back(name);
	endtask

	task automatic note_pass(input string name);
		pass_count++;
		$display("PASS %s", name);
	endtask

	task automatic note_fail(input string msg);
		fail_count++;
		$display("%s", msg);
	endtask

	// --------------------------------------------------
	// Checks called from the testbench top
	// --------------------------------------------------

	task automatic check_reset_state(input string name);
		if (tvalid || tlast) begin
			note_fail($sformatf("%s: tvalid or tlast is high right after reset", name));
		end else if (overflow_count != 64'd0) begin
			note_fail($sformatf("Mismatch %s expected %0h actual %0h", name, 64'd0,
				overflow_count));
		end else begin
			note_pass(name);
		end
	endtask

	task automatic check_overflow(input string name, input logic [63:0] expected);
		if (overflow_count != expected) begin
			note_fail($sformatf("Mismatch %s expected %0h actual %0h", name, expected,
				overflow_count));
		end else begin
			note_pass(name);
		end
	endtask

	task automatic report_summary();
		if (expected_q.size() != 0) begin
			note_fail($sformatf("missing records: %0d expected records never arrived",
				expected_q.size()));
		end
		$display("Summary: %0d tests, %0d passed, %0d failed", pass_count + fail_count,
			pass_count, fail_count);
	endtask

	// --------------------------------------------------
	// Record reassembly
	// --------------------------------------------------

	task automatic finish_record();
		logic [`ETH_LOG_RECORD_BITS-1:0] exp;
		string                           name;
		if (expected_q.size() == 0) begin
			note_fail("Unexpected record: a record arrived with no expected record queued");
		end else begin
			exp  = expected_q.pop_front();
			name = name_q.pop_front();
			if (assembled == exp) begin
				note_pass(name);
			end else begin
				note_fail($sformatf("Mismatch %s expected %0h actual %0h", name, exp, assembled));
			end
		end
	endtask

	// a badly framed record still uses up its expectation.
	task automatic drop_record(input string reason);
		string name;
		name = "unnamed";
		if (name_q.size() > 0) begin
			name = name_q.pop_front();
			expected_q.delete(0);
		end
		note_fail($sformatf("%s: %s", name, reason));
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			rec_state = LOG_IDLE;
			beat_idx  = 0;
			held      = 1'b0;
		end else begin
			// a stalled beat must stay valid and keep its data.
			if (held) begin
				if (!tvalid) begin
					note_fail("beat_hold: tvalid dropped before the beat was accepted");
				end else if (tdata != held_data) begin
					note_fail($sformatf("Mismatch beat_hold expected %0h actual %0h",
						held_data, tdata));
				end
			end
			held      = tvalid && !tready;
			held_data = tdata;

			if (tvalid && tready) begin
				if (rec_state == LOG_IDLE) begin
					assembled = '0;
				end
				assembled[beat_idx*beat_width +: beat_width] = tdata;
				rec_state = LOG_SEND;
				if (tlast) begin
					if (beat_idx == beats_per_record - 1) begin
						finish_record();
					end else begin
						drop_record($sformatf("tlast came on beat %0d instead of beat %0d",
							beat_idx + 1, beats_per_record));
					end
					beat_idx  = 0;
					rec_state = LOG_IDLE;
				end else if (beat_idx == beats_per_record - 1) begin
					drop_record("no tlast on the last beat of the record");
					beat_idx  = 0;
					rec_state = LOG_IDLE;
				end else begin
					beat_idx++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_eth_stats.sv
// --------------------------------------------------
// Testbench for the statistics collector. Drives frame
// strobes and triggers and predicts every log record.
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "eth_stats_params.svh"

module tb_eth_stats;

	localparam int burst_len      = 30;
	localparam int max_gap        = 8;
	localparam int record_budget  = 32;
	localparam int trigger_count  = 16;
	localparam int timeout_cycles =
		8 + trigger_count * (burst_len + max_gap + record_budget) + 200;

	logic        clk;
	logic        rst_n;
	logic        tx_frame_done;
	logic [15:0] tx_frame_len;
	logic        tx_frame_ok;
	logic        rx_frame_done;
	logic [15:0] rx_frame_len;
	logic        rx_frame_ok;
	logic        log_trigger;
	logic [15:0] log_id;
	logic [63:0] overflow_count;
	logic [63:0] m_axis_log_tdata;
	logic        m_axis_log_tlast;
	logic        m_axis_log_tvalid;
	logic        m_axis_log_tready;

	// reference model state.
	logic [63:0] model_ts;
	logic [63:0] tx_bytes, tx_good, tx_bad;
	logic [63:0] rx_bytes, rx_good, rx_bad;
	logic [63:0] exp_overflow;
	logic        model_busy = 1'b0;

	string       test_name;
	logic [15:0] next_id;
	logic        stall_mode = 1'b0;
	int          cycle_count = 0;
	int unsigned seed_val;

	eth_stats_collector UUT (
		.clk               (clk),
		.rst_n             (rst_n),
		.tx_frame_done     (tx_frame_done),
		.tx_frame_len      (tx_frame_len),
		.tx_frame_ok       (tx_frame_ok),
		.rx_frame_done     (rx_frame_done),
		.rx_frame_len      (rx_frame_len),
		.rx_frame_ok       (rx_frame_ok),
		.log_trigger       (log_trigger),
		.log_id            (log_id),
		.overflow_count    (overflow_count),
		.m_axis_log_tdata  (m_axis_log_tdata),
		.m_axis_log_tlast  (m_axis_log_tlast),
		.m_axis_log_tvalid (m_axis_log_tvalid),
		.m_axis_log_tready (m_axis_log_tready)
	);

	eth_stats_checker log_checker (
		.clk            (clk),
		.rst_n          (rst_n),
		.tdata          (m_axis_log_tdata),
		.tlast          (m_axis_log_tlast),
		.tvalid         (m_axis_log_tvalid),
		.tready         (m_axis_log_tready),
		.overflow_count (overflow_count)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------

	// header in the low 64 bits, then timestamp, tx and rx totals.
	function automatic logic [`ETH_LOG_RECORD_BITS-1:0] build_record(
		input logic [15:0] id, input logic [63:0] ts,
		input logic [63:0] t_bytes, input logic [63:0] t_good, input logic [63:0] t_bad,
		input logic [63:0] r_bytes, input logic [63:0] r_good, input logic [63:0] r_bad);
		logic [`ETH_LOG_RECORD_BITS-1:0] rec;
		rec          = '0;
		rec[31:0]    = `ETH_LOG_MAGIC;
		rec[47:32]   = id;
		rec[63:48]   = `ETH_LOG_LENGTH;
		rec[127:64]  = ts;
		rec[191:128] = t_bytes;
		rec[255:192] = t_good;
		rec[319:256] = t_bad;
		rec[383:320] = r_bytes;
		rec[447:384] = r_good;
		rec[511:448] = r_bad;
		return rec;
	endfunction

	// the snapshot is taken before this edge's frame strobes are added.
	always @(posedge clk) begin
		if (!rst_n) begin
			model_ts     = 64'd0;
			tx_bytes     = 64'd0;
			tx_good      = 64'd0;
			tx_bad       = 64'd0;
			rx_bytes     = 64'd0;
			rx_good      = 64'd0;
			rx_bad       = 64'd0;
			exp_overflow = 64'd0;
			model_busy   = 1'b0;
		end else begin
			if (log_trigger) begin
				if (model_busy) begin
					exp_overflow = exp_overflow + 64'd1;
				end else begin
					log_checker.push_expected(build_record(log_id, model_ts, tx_bytes, tx_good,
						tx_bad, rx_bytes, rx_good, rx_bad), test_name);
					model_busy = 1'b1;
				end
			end
			if (m_axis_log_tvalid && m_axis_log_tready && m_axis_log_tlast) begin
				model_busy = 1'b0;
			end
			if (tx_frame_done) begin
				tx_bytes = tx_bytes + 64'(tx_frame_len);
				if (tx_frame_ok) tx_good = tx_good + 64'd1;
				else tx_bad = tx_bad + 64'd1;
			end
			if (rx_frame_done) begin
				rx_bytes = rx_bytes + 64'(rx_frame_len);
				if (rx_frame_ok) rx_good = rx_good + 64'd1;
				else rx_bad = rx_bad + 64'd1;
			end
			model_ts = model_ts + 64'd1;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("Test failures found");
			$finish;
		end
	end

	// tready is high always, or low about one cycle in four when stalling.
	initial begin
		m_axis_log_tready = 1'b1;
		forever begin
			@(negedge clk);
			m_axis_log_tready = stall_mode ? (($urandom % 4) != 0) : 1'b1;
		end
	end

	// --------------------------------------------------
	// Stimulus tasks, all starting and ending on a falling edge
	// --------------------------------------------------

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic clear_frames();
		tx_frame_done = 1'b0;
		rx_frame_done = 1'b0;
	endtask

	task automatic send_frames(input int n, input logic tx_en, input logic rx_en,
		input logic dense);
		for (int i = 0; i < n; i++) begin
			tx_frame_done = tx_en && (dense || ($urandom % 2) == 0);
			tx_frame_len  = 16'(64 + $urandom % 1455);
			tx_frame_ok   = (($urandom % 4) != 0);
			rx_frame_done = rx_en && (dense || ($urandom % 2) == 0);
			rx_frame_len  = 16'(64 + $urandom % 1455);
			rx_frame_ok   = (($urandom % 4) != 0);
			@(negedge clk);
		end
		clear_frames();
	endtask

	task automatic fire_trigger(input string name, input logic with_frames);
		test_name   = name;
		log_trigger = 1'b1;
		log_id      = next_id;
		next_id     = next_id + 16'd1;
		if (with_frames) begin
			tx_frame_done = 1'b1;
			tx_frame_len  = 16'(64 + $urandom % 1455);
			tx_frame_ok   = 1'b1;
			rx_frame_done = 1'b1;
			rx_frame_len  = 16'(64 + $urandom % 1455);
			rx_frame_ok   = 1'b0;
		end
		@(negedge clk);
		log_trigger = 1'b0;
		clear_frames();
	endtask

	task automatic wait_idle();
		while (model_busy) @(negedge clk);
	endtask

	initial begin
		seed_val      = $urandom(23626);
		rst_n         = 1'b0;
		tx_frame_done = 1'b0;
		tx_frame_len  = 16'd0;
		tx_frame_ok   = 1'b0;
		rx_frame_done = 1'b0;
		rx_frame_len  = 16'd0;
		rx_frame_ok   = 1'b0;
		log_trigger   = 1'b0;
		log_id        = 16'd0;
		next_id       = 16'h0100;
		test_name     = "none";
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		log_checker.check_reset_state("reset_state");
		fire_trigger("empty_record", 1'b0);
		wait_idle();

		// one direction at a time.
		for (int round = 0; round < 2; round++) begin
			send_frames(burst_len, 1'b1, 1'b0, 1'b0);
			fire_trigger("tx_only", 1'b0);
			wait_idle();
			idle_cycles(1 + int'($urandom % max_gap));
			send_frames(burst_len, 1'b0, 1'b1, 1'b0);
			fire_trigger("rx_only", 1'b0);
			wait_idle();
		end

		// both directions every cycle, also in the trigger's own cycle.
		send_frames(burst_len, 1'b1, 1'b1, 1'b1);
		fire_trigger("both_same_cycle", 1'b1);
		wait_idle();
		fire_trigger("both_after", 1'b0);
		wait_idle();

		stall_mode = 1'b1;
		for (int n = 0; n < 4; n++) begin
			send_frames(10, 1'b1, 1'b1, 1'b0);
			idle_cycles(1 + int'($urandom % max_gap));
			fire_trigger("stalled_stream", 1'b0);
			wait_idle();
		end

		// three triggers land while the first record is in flight.
		fire_trigger("overflow_first", 1'b0);
		for (int n = 0; n < 3; n++) begin
			idle_cycles(int'($urandom % 2));
			fire_trigger("dropped", 1'b0);
		end
		wait_idle();
		fire_trigger("after_tlast", 1'b0);
		wait_idle();
		stall_mode = 1'b0;
		idle_cycles(2);
		log_checker.check_overflow("overflow_count", exp_overflow);

		idle_cycles(4);
		log_checker.report_summary();
		if (log_checker.fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/eth_frame_pkg.sv
logic/eth_log_pkg.sv
logic/eth_frame_counter.sv
logic/eth_stats_log_packer.sv
logic/eth_stats_collector.sv
sim/eth_stats_checker.sv
sim/tb_eth_stats.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the statistics testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 --top-module tb_eth_stats -f list.f -o tb_eth_stats_sim \
	&& ./obj_dir/tb_eth_stats_sim | tee sim.log \
	|| { echo "build or run failed"; exit 1; }

grep -q 'All tests passed!' sim.log \
	&& echo "simulation PASSED" \
	|| { echo "simulation FAILED"; exit 1; }
